// ==== hdl/rv32_dx_pkg.sv ====
`default_nettype none

package rv32_dx_pkg;

    localparam int XLEN = 32;

    // major opcodes.
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } br_cond_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_IMM, WB_LINK
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, viewed per format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     src_a_pc;
        logic     src_b_imm;
        br_cond_e br_cond;
        logic     jalr;
        wb_sel_e  wb_sel;
        logic     reg_write;
    } ctrl_word_t;

    typedef struct packed {
        logic            valid;
        ctrl_word_t      ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        logic            br_pred;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] link;
        logic [XLEN-1:0] imm;
        wb_sel_e         wb_sel;
        logic            br_taken;
        logic [XLEN-1:0] br_target;
        logic            mispredict;
    } ex_result_t;

endpackage

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  rv32_dx_pkg::instr_u          instr_i,
    output logic [4:0]                   rs1_addr_o,
    output logic [4:0]                   rs2_addr_o,
    output logic [4:0]                   rd_o,
    output logic [rv32_dx_pkg::XLEN-1:0] imm_o,
    output rv32_dx_pkg::ctrl_word_t      ctrl_o,
    output logic                         legal_o
);
    import rv32_dx_pkg::*;

    // funct3 picks the operation, alt selects sub or arithmetic shift.
    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // register fields sit at the same place in every format that has them.
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_o       = instr_i.r.rd;

    always_comb begin
        ctrl_o  = '0;
        imm_o   = '0;
        legal_o = 1'b1;
        case (instr_i.r.opcode)
            OP_REG: begin
                ctrl_o.alu_op    = alu_from_funct(instr_i.r.funct3, instr_i.r.funct7[5]);
                ctrl_o.wb_sel    = WB_ALU;
                ctrl_o.reg_write = 1'b1;
            end
            OP_IMM: begin
                imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                // only srai looks at bit 30; addi has no subtract form.
                ctrl_o.alu_op    = alu_from_funct(instr_i.i.funct3,
                                                  instr_i.i.funct3 == 3'b101 &&
                                                  instr_i.i.imm[10]);
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.wb_sel    = WB_ALU;
                ctrl_o.reg_write = 1'b1;
            end
            OP_LUI: begin
                imm_o            = {instr_i.u.imm, 12'b0};
                ctrl_o.wb_sel    = WB_IMM;
                ctrl_o.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                imm_o            = {instr_i.u.imm, 12'b0};
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.wb_sel    = WB_ALU;
                ctrl_o.reg_write = 1'b1;
            end
            OP_JAL: begin
                imm_o = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                         instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
                ctrl_o.br_cond   = BR_JUMP;
                ctrl_o.wb_sel    = WB_LINK;
                ctrl_o.reg_write = 1'b1;
            end
            OP_JALR: begin
                imm_o            = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                ctrl_o.br_cond   = BR_JUMP;
                ctrl_o.jalr      = 1'b1;
                ctrl_o.wb_sel    = WB_LINK;
                ctrl_o.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                imm_o = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                         instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                case (instr_i.b.funct3)
                    3'b000:  ctrl_o.br_cond = BR_EQ;
                    3'b001:  ctrl_o.br_cond = BR_NE;
                    3'b100:  ctrl_o.br_cond = BR_LT;
                    3'b101:  ctrl_o.br_cond = BR_GE;
                    3'b110:  ctrl_o.br_cond = BR_LTU;
                    3'b111:  ctrl_o.br_cond = BR_GEU;
                    default: legal_o = 1'b0;
                endcase
            end
            default: begin
                legal_o = 1'b0;
            end
        endcase
        // illegal words leave the decoder as a bubble.
        if (!legal_o) begin
            ctrl_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [4:0]                   rs1_addr_i,
    input  logic [4:0]                   rs2_addr_i,
    output logic [rv32_dx_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv32_dx_pkg::XLEN-1:0] rs2_data_o,
    input  logic                         we_i,
    input  logic [4:0]                   wr_addr_i,
    input  logic [rv32_dx_pkg::XLEN-1:0] wr_data_i
);
    import rv32_dx_pkg::*;

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we_i && wr_addr_i != 5'd0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write data is bypassed so decode sees the value retiring this cycle.
    always_comb begin
        if (rs1_addr_i == 5'd0) begin
            rs1_data_o = '0;
        end else if (we_i && wr_addr_i == rs1_addr_i) begin
            rs1_data_o = wr_data_i;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == 5'd0) begin
            rs2_data_o = '0;
        end else if (we_i && wr_addr_i == rs2_addr_i) begin
            rs2_data_o = wr_data_i;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_i,
    input  rv32_dx_pkg::id_ex_t d_i,
    output rv32_dx_pkg::id_ex_t q_o
);
    import rv32_dx_pkg::*;

    logic            valid_q;
    ctrl_word_t      ctrl_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_val_q;
    logic [XLEN-1:0] rs2_val_q;
    logic [XLEN-1:0] imm_q;
    logic [4:0]      rd_q;
    logic            br_pred_q;

    // an invalid entry is loaded as a bubble with all control cleared.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (load_i) begin
            valid_q <= d_i.valid;
            ctrl_q  <= d_i.valid ? d_i.ctrl : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_q      <= d_i.pc;
            rs1_val_q <= d_i.rs1_val;
            rs2_val_q <= d_i.rs2_val;
            imm_q     <= d_i.imm;
            rd_q      <= d_i.rd;
            br_pred_q <= d_i.br_pred;
        end
    end

    assign q_o = '{valid: valid_q, ctrl: ctrl_q, pc: pc_q, rs1_val: rs1_val_q,
                   rs2_val: rs2_val_q, imm: imm_q, rd: rd_q, br_pred: br_pred_q};

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  rv32_dx_pkg::id_ex_t     id_ex_i,
    output rv32_dx_pkg::ex_result_t result_o
);
    import rv32_dx_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;
    logic            taken;
    logic            is_ctrl;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] jalr_sum;

    assign op_a  = id_ex_i.ctrl.src_a_pc ? id_ex_i.pc : id_ex_i.rs1_val;
    assign op_b  = id_ex_i.ctrl.src_b_imm ? id_ex_i.imm : id_ex_i.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    // branches always compare the two register values.
    always_comb begin
        case (id_ex_i.ctrl.br_cond)
            BR_EQ:   taken = id_ex_i.rs1_val == id_ex_i.rs2_val;
            BR_NE:   taken = id_ex_i.rs1_val != id_ex_i.rs2_val;
            BR_LT:   taken = $signed(id_ex_i.rs1_val) < $signed(id_ex_i.rs2_val);
            BR_GE:   taken = $signed(id_ex_i.rs1_val) >= $signed(id_ex_i.rs2_val);
            BR_LTU:  taken = id_ex_i.rs1_val < id_ex_i.rs2_val;
            BR_GEU:  taken = id_ex_i.rs1_val >= id_ex_i.rs2_val;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_ctrl  = id_ex_i.ctrl.br_cond != BR_NONE;
    assign jalr_sum = id_ex_i.rs1_val + id_ex_i.imm;
    assign target   = id_ex_i.ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0}
                                        : id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        result_o.valid      = id_ex_i.valid;
        result_o.reg_write  = id_ex_i.ctrl.reg_write;
        result_o.rd         = id_ex_i.rd;
        result_o.alu_out    = alu_out;
        result_o.link       = id_ex_i.pc + XLEN'(4);
        result_o.imm        = id_ex_i.imm;
        result_o.wb_sel     = id_ex_i.ctrl.wb_sel;
        // plain alu ops report no branch activity.
        result_o.br_taken   = is_ctrl && taken;
        result_o.br_target  = is_ctrl ? target : '0;
        result_o.mispredict = is_ctrl && (taken != id_ex_i.br_pred);
    end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall_i,
    input  rv32_dx_pkg::ex_result_t      result_i,
    output logic                         rf_we_o,
    output logic [4:0]                   rf_addr_o,
    output logic [rv32_dx_pkg::XLEN-1:0] rf_data_o,
    output logic                         wb_valid_o,
    output logic                         wb_we_o,
    output logic [4:0]                   wb_rd_o,
    output logic [rv32_dx_pkg::XLEN-1:0] wb_data_o,
    output logic                         br_taken_o,
    output logic [rv32_dx_pkg::XLEN-1:0] br_target_o,
    output logic                         mispredict_o
);
    import rv32_dx_pkg::*;

    logic            fire;
    logic [XLEN-1:0] wb_value;

    // a result retires on the same edge that loads id/ex.
    assign fire = result_i.valid && !stall_i;

    always_comb begin
        case (result_i.wb_sel)
            WB_IMM:  wb_value = result_i.imm;
            WB_LINK: wb_value = result_i.link;
            default: wb_value = result_i.alu_out;
        endcase
    end

    assign rf_we_o   = fire && result_i.reg_write && result_i.rd != 5'd0;
    assign rf_addr_o = result_i.rd;
    assign rf_data_o = wb_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o   <= 1'b0;
            wb_we_o      <= 1'b0;
            br_taken_o   <= 1'b0;
            mispredict_o <= 1'b0;
        end else begin
            wb_valid_o   <= fire;
            wb_we_o      <= rf_we_o;
            br_taken_o   <= fire && result_i.br_taken;
            mispredict_o <= fire && result_i.mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wb_rd_o     <= result_i.rd;
            wb_data_o   <= wb_value;
            br_target_o <= result_i.br_target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv32_dx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_dx_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [31:0]                  instr_i,
    input  logic [rv32_dx_pkg::XLEN-1:0] pc_i,
    input  logic                         br_pred_i,
    input  logic                         valid_i,
    input  logic                         stall_i,
    output logic                         wb_valid_o,
    output logic                         wb_we_o,
    output logic [4:0]                   wb_rd_o,
    output logic [rv32_dx_pkg::XLEN-1:0] wb_data_o,
    output logic                         br_taken_o,
    output logic [rv32_dx_pkg::XLEN-1:0] br_target_o,
    output logic                         mispredict_o
);
    import rv32_dx_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    ctrl_word_t      ctrl;
    logic            legal;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    ex_result_t      ex_result;
    logic            rf_we;
    logic [4:0]      rf_addr;
    logic [XLEN-1:0] rf_data;

    instr_decoder i_decoder (
        .instr_i    (instr_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_o       (rd),
        .imm_o      (imm),
        .ctrl_o     (ctrl),
        .legal_o    (legal)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .wr_addr_i  (rf_addr),
        .wr_data_i  (rf_data)
    );

    // an illegal opcode enters id/ex as a bubble.
    assign id_ex_d = '{valid: valid_i && legal, ctrl: ctrl, pc: pc_i, rs1_val: rs1_data,
                       rs2_val: rs2_data, imm: imm, rd: rd, br_pred: br_pred_i};

    id_ex_reg i_id_ex_reg (
        .clk    (clk),
        .rst    (rst),
        .load_i (!stall_i),
        .d_i    (id_ex_d),
        .q_o    (id_ex_q)
    );

    exec_unit i_exec_unit (
        .id_ex_i  (id_ex_q),
        .result_o (ex_result)
    );

    writeback_stage i_writeback (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .result_i     (ex_result),
        .rf_we_o      (rf_we),
        .rf_addr_o    (rf_addr),
        .rf_data_o    (rf_data),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .br_taken_o   (br_taken_o),
        .br_target_o  (br_target_o),
        .mispredict_o (mispredict_o)
    );

endmodule

`default_nettype wire

// ==== bench/rv32_dx_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv32_dx_tb;
    import rv32_dx_pkg::*;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        br_pred;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic        mispredict;
    } entry_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        br_pred_i;
    logic        valid_i;
    logic        stall_i;
    logic        wb_valid_o;
    logic        wb_we_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        br_taken_o;
    logic [31:0] br_target_o;
    logic        mispredict_o;

    entry_t      stim_q[$];
    entry_t      want_q[$];
    int          out_idx = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    logic [31:0] rng_state = 32'd91;

    rv32_dx_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .br_pred_i    (br_pred_i),
        .valid_i      (valid_i),
        .stall_i      (stall_i),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .br_taken_o   (br_taken_o),
        .br_target_o  (br_target_o),
        .mispredict_o (mispredict_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        instr_u w;
        w = '0;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = OP_REG;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [31:0] imm,
                                          input logic [6:0] op);
        instr_u w;
        w = '0;
        w.i.imm    = imm[11:0];
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [31:0] imm);
        instr_u w;
        w = '0;
        w.u.imm    = imm[19:0];
        w.u.rd     = rd;
        w.u.opcode = op;
        return w;
    endfunction

    // the format drops bit 0 of the byte offset.
    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [31:0] imm);
        instr_u w;
        w = '0;
        w.b.imm12   = imm[12];
        w.b.imm10_5 = imm[10:5];
        w.b.rs2     = rs2;
        w.b.rs1     = rs1;
        w.b.funct3  = f3;
        w.b.imm4_1  = imm[4:1];
        w.b.imm11   = imm[11];
        w.b.opcode  = OP_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [31:0] imm);
        instr_u w;
        w = '0;
        w.j.imm20    = imm[20];
        w.j.imm10_1  = imm[10:1];
        w.j.imm11    = imm[11];
        w.j.imm19_12 = imm[19:12];
        w.j.rd       = rd;
        w.j.opcode   = OP_JAL;
        return w;
    endfunction

    task automatic add_entry(input logic valid, input logic [31:0] pc, input logic [31:0] instr,
                             input logic pred, input logic we, input logic [4:0] rd,
                             input logic [31:0] data, input logic taken,
                             input logic [31:0] target, input logic mis);
        stim_q.push_back('{valid, pc, instr, pred, we, rd, data, taken, target, mis});
    endtask

    // plain ops alternate the prediction so a stray mispredict flag would show.
    task automatic alu_entry(input logic [31:0] pc, input logic [31:0] instr, input logic we,
                             input logic [4:0] rd, input logic [31:0] data);
        add_entry(1'b1, pc, instr, pc[2], we, rd, data, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic br_entry(input logic [31:0] pc, input logic [31:0] instr, input logic pred,
                            input logic taken, input logic [31:0] target, input logic mis);
        add_entry(1'b1, pc, instr, pred, 1'b0, 5'd0, 32'h0, taken, target, mis);
    endtask

    // the branches below rely on x1 = -5, x2 = x3 = 1, x16 = 0x7fffffff and x20 = 0.
    task automatic build_table();
        alu_entry(32'h100, enc_i(3'b000, 5'd1, 5'd0, -5, OP_IMM), 1'b1, 5'd1, 32'hFFFFFFFB);
        alu_entry(32'h104, enc_i(3'b010, 5'd2, 5'd1, -3, OP_IMM), 1'b1, 5'd2, 32'h1);
        alu_entry(32'h108, enc_i(3'b011, 5'd3, 5'd1, -1, OP_IMM), 1'b1, 5'd3, 32'h1);
        alu_entry(32'h10C, enc_i(3'b100, 5'd4, 5'd1, 'h0F0, OP_IMM), 1'b1, 5'd4, 32'hFFFFFF0B);
        alu_entry(32'h110, enc_i(3'b101, 5'd5, 5'd4, 'h404, OP_IMM), 1'b1, 5'd5, 32'hFFFFFFF0);
        alu_entry(32'h114, enc_u(OP_LUI, 5'd6, 'h12345), 1'b1, 5'd6, 32'h12345000);
        alu_entry(32'h118, enc_u(OP_AUIPC, 5'd7, 'h1), 1'b1, 5'd7, 32'h1118);
        // each result in this chain feeds the next one.
        alu_entry(32'h11C, enc_r(7'h00, 3'b000, 5'd8, 5'd6, 5'd7), 1'b1, 5'd8, 32'h12346118);
        alu_entry(32'h120, enc_r(7'h20, 3'b000, 5'd9, 5'd8, 5'd1), 1'b1, 5'd9, 32'h1234611D);
        alu_entry(32'h124, enc_r(7'h00, 3'b001, 5'd10, 5'd9, 5'd2), 1'b1, 5'd10, 32'h2468C23A);
        alu_entry(32'h128, enc_r(7'h00, 3'b010, 5'd11, 5'd1, 5'd10), 1'b1, 5'd11, 32'h1);
        alu_entry(32'h12C, enc_r(7'h00, 3'b011, 5'd12, 5'd0, 5'd11), 1'b1, 5'd12, 32'h1);
        alu_entry(32'h130, enc_r(7'h00, 3'b100, 5'd13, 5'd12, 5'd1), 1'b1, 5'd13, 32'hFFFFFFFA);
        alu_entry(32'h134, enc_r(7'h20, 3'b101, 5'd14, 5'd13, 5'd2), 1'b1, 5'd14, 32'hFFFFFFFD);
        alu_entry(32'h138, enc_r(7'h00, 3'b101, 5'd15, 5'd14, 5'd2), 1'b1, 5'd15, 32'h7FFFFFFE);
        alu_entry(32'h13C, enc_r(7'h00, 3'b110, 5'd16, 5'd15, 5'd2), 1'b1, 5'd16, 32'h7FFFFFFF);
        alu_entry(32'h140, enc_r(7'h00, 3'b111, 5'd17, 5'd16, 5'd6), 1'b1, 5'd17, 32'h12345000);
        alu_entry(32'h144, enc_r(7'h00, 3'b000, 5'd0, 5'd17, 5'd17), 1'b0, 5'd0, 32'h0);
        alu_entry(32'h148, enc_r(7'h00, 3'b000, 5'd18, 5'd0, 5'd17), 1'b1, 5'd18, 32'h12345000);
        // this invalid slot must neither retire nor write x20.
        add_entry(1'b0, 32'h14C, enc_i(3'b000, 5'd20, 5'd0, 'h7FF, OP_IMM), 1'b0, 1'b0, 5'd0,
                  32'h0, 1'b0, 32'h0, 1'b0);
        br_entry(32'h150, enc_b(3'b000, 5'd2, 5'd3, 16), 1'b1, 1'b1, 32'h160, 1'b0);
        br_entry(32'h154, enc_b(3'b000, 5'd1, 5'd2, 8), 1'b1, 1'b0, 32'h15C, 1'b1);
        br_entry(32'h158, enc_b(3'b001, 5'd1, 5'd2, -8), 1'b0, 1'b1, 32'h150, 1'b1);
        br_entry(32'h15C, enc_b(3'b001, 5'd2, 5'd3, 32), 1'b0, 1'b0, 32'h17C, 1'b0);
        br_entry(32'h160, enc_b(3'b100, 5'd1, 5'd2, 64), 1'b1, 1'b1, 32'h1A0, 1'b0);
        br_entry(32'h164, enc_b(3'b100, 5'd2, 5'd1, -16), 1'b1, 1'b0, 32'h154, 1'b1);
        br_entry(32'h168, enc_b(3'b101, 5'd2, 5'd1, 12), 1'b0, 1'b1, 32'h174, 1'b1);
        br_entry(32'h16C, enc_b(3'b101, 5'd1, 5'd2, 4), 1'b0, 1'b0, 32'h170, 1'b0);
        br_entry(32'h170, enc_b(3'b110, 5'd2, 5'd1, 256), 1'b1, 1'b1, 32'h270, 1'b0);
        br_entry(32'h174, enc_b(3'b110, 5'd1, 5'd2, -32), 1'b0, 1'b0, 32'h154, 1'b0);
        br_entry(32'h178, enc_b(3'b111, 5'd1, 5'd16, 20), 1'b0, 1'b1, 32'h18C, 1'b1);
        br_entry(32'h17C, enc_b(3'b111, 5'd16, 5'd1, 8), 1'b1, 1'b0, 32'h184, 1'b1);
        br_entry(32'h180, enc_b(3'b000, 5'd20, 5'd0, 24), 1'b1, 1'b1, 32'h198, 1'b0);
        add_entry(1'b1, 32'h184, enc_j(5'd21, 'h40), 1'b1, 1'b1, 5'd21, 32'h188, 1'b1,
                  32'h1C4, 1'b0);
        add_entry(1'b1, 32'h188, enc_i(3'b000, 5'd22, 5'd21, 5, OP_JALR), 1'b0, 1'b1, 5'd22,
                  32'h18C, 1'b1, 32'h18C, 1'b1);
        alu_entry(32'h18C, enc_i(3'b000, 5'd23, 5'd22, 1, OP_IMM), 1'b1, 5'd23, 32'h18D);
        add_entry(1'b1, 32'h190, enc_j(5'd0, -8), 1'b1, 1'b0, 5'd0, 32'h0, 1'b1, 32'h188, 1'b0);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual, inout bit ok);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h got %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_reset_state(inout bit ok);
        compare("wb_valid_o", 32'h0, 32'(wb_valid_o), ok);
        compare("wb_we_o", 32'h0, 32'(wb_we_o), ok);
        compare("br_taken_o", 32'h0, 32'(br_taken_o), ok);
        compare("mispredict_o", 32'h0, 32'(mispredict_o), ok);
    endtask

    task automatic check_output(input entry_t e);
        bit ok;
        ok = 1'b1;
        compare("wb_we_o", 32'(e.we), 32'(wb_we_o), ok);
        if (e.we) begin
            compare("wb_rd_o", 32'(e.rd), 32'(wb_rd_o), ok);
            compare("wb_data_o", e.data, wb_data_o, ok);
        end
        compare("br_taken_o", 32'(e.taken), 32'(br_taken_o), ok);
        compare("br_target_o", e.target, br_target_o, ok);
        compare("mispredict_o", 32'(e.mispredict), 32'(mispredict_o), ok);
        if (ok) begin
            pass_count++;
            $display("result %0d pc %h passed", out_idx, e.pc);
        end else begin
            fail_count++;
            $display("result %0d pc %h had mismatches", out_idx, e.pc);
        end
    endtask

    // roughly one cycle in four is stalled.
    task automatic next_stall();
        rng_state = xorshift32(rng_state);
        stall_i   = rng_state[1:0] == 2'b00;
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid_o === 1'b1) begin
            assert (out_idx < want_q.size()) else begin
                $display("an extra result appeared after all entries had retired");
                fail_count++;
            end
            if (out_idx < want_q.size()) begin
                check_output(want_q[out_idx]);
            end
            out_idx++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results seen",
                     cycle_count, out_idx, want_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        bit reset_ok;
        clk       = 1'b0;
        rst       = 1'b1;
        instr_i   = 32'h0;
        pc_i      = 32'h0;
        br_pred_i = 1'b0;
        valid_i   = 1'b0;
        stall_i   = 1'b0;
        reset_ok  = 1'b1;
        build_table();
        foreach (stim_q[k]) begin
            if (stim_q[k].valid) begin
                want_q.push_back(stim_q[k]);
            end
        end
        cycle_limit = 8 + 4 * stim_q.size() + 20;

        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #2;
            check_reset_state(reset_ok);
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_reset_state(reset_ok);
        if (reset_ok) begin
            pass_count++;
            $display("reset state passed");
        end else begin
            fail_count++;
            $display("reset state had mismatches");
        end

        // an entry is held until an edge with stall low takes it.
        for (int k = 0; k < stim_q.size(); k++) begin
            instr_i   = stim_q[k].instr;
            pc_i      = stim_q[k].pc;
            br_pred_i = stim_q[k].br_pred;
            valid_i   = stim_q[k].valid;
            next_stall();
            @(posedge clk);
            while (stall_i) begin
                #2;
                next_stall();
                @(posedge clk);
            end
            #2;
        end
        valid_i = 1'b0;

        while (out_idx < want_q.size()) begin
            next_stall();
            @(posedge clk);
            #2;
        end
        stall_i = 1'b0;
        repeat (4) @(posedge clk);
        #2;

        $display("summary: %0d passed, %0d failed, %0d of %0d results seen",
                 pass_count, fail_count, out_idx, want_q.size());
        if (fail_count == 0 && out_idx == want_q.size()) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_dx.f ====
hdl/rv32_dx_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/id_ex_reg.sv
hdl/exec_unit.sv
hdl/writeback_stage.sv
hdl/rv32_dx_top.sv
bench/rv32_dx_tb.sv
